/* tb.f */
hdl/mc_pkg.sv
hdl/host_bridge.sv
hdl/encoder_bank.sv
hdl/motor_bank.sv
hdl/reg_read_mux.sv
hdl/motor_ctrl_top.sv
testbench/tb_motor_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the motor controller register core testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
        --top-module tb_motor_ctrl -f tb.f -o sim_motor_ctrl; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_motor_ctrl 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Regression passed" <<< "$output"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* testbench/tb_motor_ctrl.sv */
// testbench for the motor controller register core
// credit-based host driver, register reference model, response checker
`timescale 1ns/1ps

module tb_motor_ctrl import mc_pkg::*; ();

    localparam int NUM_MOTORS   = 4;
    localparam int NUM_ENCODERS = 4;
    localparam int REQ_DEPTH    = 4;
    localparam int TEST_CYCLES  = 800;                          // rough length of all tests
    localparam int LIMIT_NS     = (TEST_CYCLES * 2 + 400) * 100;

    logic                                 sysclk;
    logic                                 rst_n;
    logic                                 req_valid;
    logic                                 req_write;
    addr_t                                req_addr;
    data_t                                req_wdata;
    logic                                 req_credit;
    logic                                 rsp_credit;
    logic                                 rsp_valid;
    data_t                                rsp_data;
    logic [BOARD_ID_W-1:0]                board_id;
    logic [NUM_ENCODERS-1:0]              enc_a;
    logic [NUM_ENCODERS-1:0]              enc_b;
    logic [NUM_MOTORS-1:0][MOT_CMD_W-1:0] mot_cmd;
    logic [NUM_MOTORS-1:0]                amp_en;
    logic                                 wdog_timeout;

    // register model
    logic [MOT_CMD_W-1:0] m_cmd [NUM_MOTORS];
    logic [NUM_MOTORS-1:0] m_amp;
    logic [ENC_POS_W-1:0] m_pos [NUM_ENCODERS];
    logic [ENC_ERR_W-1:0] m_err [NUM_ENCODERS];
    data_t                m_period;
    logic                 m_timeout;

    data_t exp_q [$];       // expected read data in issue order
    int    req_cred;        // host request credits held
    int    pend_cred;       // response credits owed to the bridge
    logic  hold_cred;       // withhold rsp_credit
    int    credit_pulses;
    int    issued;
    int    reads_issued;
    int    rsp_count;

    motor_ctrl_top #(
        .NUM_MOTORS(NUM_MOTORS), .NUM_ENCODERS(NUM_ENCODERS), .REQ_DEPTH(REQ_DEPTH)
    ) motor_ctrl_top_inst (
        .sysclk, .rst_n, .req_valid, .req_write, .req_addr, .req_wdata, .req_credit,
        .rsp_credit, .rsp_valid, .rsp_data, .board_id, .enc_a, .enc_b,
        .mot_cmd, .amp_en, .wdog_timeout
    );

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH at %0t: %s got %b expected %b",
                                     $time, name, got, exp));
    endtask

    task automatic check_cmd(input string name, input logic [MOT_CMD_W-1:0] got,
                             input logic [MOT_CMD_W-1:0] exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
    endtask

    function automatic addr_t make_addr(input dev_t dev, input int ch, input ofs_t ofs);
        return {dev, 4'h0, chan_t'(ch), ofs};
    endfunction

    // expected read value from the address map
    function automatic data_t ref_read(input addr_t a);
        data_t v;
        int    ch;
        ofs_t  ofs;
        v   = '0;
        ch  = int'(a[7:4]);
        ofs = a[3:0];
        case (dev_t'(a[15:12]))
            DEV_BOARD: begin
                if (ofs == OFS_STATUS) begin
                    v[BOARD_ID_W-1:0] = board_id;
                    v[4] = m_timeout;
                    for (int i = 0; i < NUM_MOTORS; i++)
                        v[8 + i] = m_amp[i];
                end else if (ofs == OFS_WDOG_PERIOD) begin
                    v = m_period;
                end
            end
            DEV_ENC: if (ch < NUM_ENCODERS) begin
                if (ofs == OFS_ENC_POS)
                    v = {{(32 - ENC_POS_W){m_pos[ch][ENC_POS_W-1]}}, m_pos[ch]};
                else if (ofs == OFS_ENC_ERR)
                    v = {{(32 - ENC_ERR_W){1'b0}}, m_err[ch]};
            end
            DEV_MOT: if (ch < NUM_MOTORS) begin
                if (ofs == OFS_MOT_CMD)      v = {{(32 - MOT_CMD_W){1'b0}}, m_cmd[ch]};
                else if (ofs == OFS_MOT_AMP) v = {31'h0, m_amp[ch]};
            end
            default: ;
        endcase
        return v;
    endfunction

    function automatic void model_write(input addr_t a, input data_t d);
        int   ch;
        ofs_t ofs;
        ch  = int'(a[7:4]);
        ofs = a[3:0];
        case (dev_t'(a[15:12]))
            DEV_BOARD: begin
                if (ofs == OFS_WDOG_PERIOD)         m_period  = d;
                else if (ofs == OFS_STATUS && d[0]) m_timeout = 1'b0;
            end
            DEV_ENC: if (ch < NUM_ENCODERS) begin
                if (ofs == OFS_ENC_POS)      m_pos[ch] = d[ENC_POS_W-1:0];
                else if (ofs == OFS_ENC_ERR) m_err[ch] = '0;
            end
            DEV_MOT: if (ch < NUM_MOTORS) begin
                if (ofs == OFS_MOT_CMD)                    m_cmd[ch] = d[MOT_CMD_W-1:0];
                else if (ofs == OFS_MOT_AMP && !m_timeout) m_amp[ch] = d[0];  // locked out
            end
            default: ;
        endcase
    endfunction

    task automatic idle(input int n);
        repeat (n) @(posedge sysclk);
        #1;
    endtask

    // one request only while a credit is held
    task automatic send(input logic wr, input addr_t a, input data_t d);
        while (req_cred == 0) idle(1);
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = a;
        req_wdata = d;
        req_cred  = req_cred - 1;
        issued    = issued + 1;
        if (wr) begin
            model_write(a, d);
        end else begin
            exp_q.push_back(ref_read(a));
            reads_issued = reads_issued + 1;
        end
        idle(1);
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0) begin
            idle(1);
            cnt = cnt + 1;
            if (cnt > 300) report_failure("read responses stopped arriving");
        end
    endtask

    // dir +1 forward, -1 backward, 0 both inputs at once
    task automatic enc_step(input int ch, input int dir);
        if (dir == 0) begin
            enc_a[ch] = ~enc_a[ch];
            enc_b[ch] = ~enc_b[ch];
            if (m_err[ch] != '1) m_err[ch] = m_err[ch] + ENC_ERR_W'(1);
        end else if ((enc_a[ch] == enc_b[ch]) == (dir > 0)) begin
            enc_a[ch] = ~enc_a[ch];
        end else begin
            enc_b[ch] = ~enc_b[ch];
        end
        if (dir > 0) m_pos[ch] = m_pos[ch] + ENC_POS_W'(1);
        if (dir < 0) m_pos[ch] = m_pos[ch] - ENC_POS_W'(1);
        idle(2);  // let the synchronizer see it
    endtask

    // response checker sampled mid-cycle
    always @(negedge sysclk) begin
        if (rst_n && rsp_valid) begin
            if (exp_q.size() == 0) report_failure("response arrived with no read outstanding");
            check_data("rsp_data", rsp_data, exp_q.pop_front());
            rsp_count = rsp_count + 1;
            pend_cred = pend_cred + 1;
        end
        if (rst_n && req_credit) begin
            credit_pulses = credit_pulses + 1;
            req_cred      = req_cred + 1;
        end
    end

    // return one response credit per cycle unless held
    always @(posedge sysclk) begin
        #1;
        if (rst_n && !hold_cred && pend_cred > 0) begin
            rsp_credit = 1'b1;
            pend_cred  = pend_cred - 1;
        end else begin
            rsp_credit = 1'b0;
        end
    end

    initial begin
        #(LIMIT_NS);
        report_failure("simulation ran past its time limit");
    end

    initial begin
        data_t r;
        int    fwd;
        int    base;
        int    cnt;
        r         = $urandom(8);
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        rsp_credit = 1'b0;
        board_id  = 4'hA;
        enc_a     = '0;
        enc_b     = '0;
        hold_cred = 1'b0;
        req_cred  = REQ_DEPTH;
        pend_cred = 0;
        credit_pulses = 0;
        issued    = 0;
        reads_issued = 0;
        rsp_count = 0;
        m_amp     = '0;
        m_period  = '0;
        m_timeout = 1'b0;
        for (int i = 0; i < NUM_MOTORS; i++) m_cmd[i] = '0;
        for (int i = 0; i < NUM_ENCODERS; i++) begin
            m_pos[i] = '0;
            m_err[i] = '0;
        end
        idle(2);
        rst_n = 1'b1;

        // random write and read-back of motor commands and enables
        for (int k = 0; k < 12; k++) begin
            cnt = $urandom_range(NUM_MOTORS - 1, 0);
            r   = $urandom;
            send(1'b1, make_addr(DEV_MOT, cnt, OFS_MOT_CMD), r);
            send(1'b1, make_addr(DEV_MOT, cnt, OFS_MOT_AMP), {31'h0, r[16]});
            send(1'b0, make_addr(DEV_MOT, cnt, OFS_MOT_CMD), '0);
            send(1'b0, make_addr(DEV_MOT, cnt, OFS_MOT_AMP), '0);
        end
        send(1'b0, make_addr(DEV_MOT, 6, OFS_MOT_CMD), '0);  // channel out of range
        send(1'b0, make_addr(4'h5, 0, 4'h0), '0);            // unmapped device
        wait_drain();
        for (int i = 0; i < NUM_MOTORS; i++) begin
            check_cmd($sformatf("mot_cmd[%0d]", i), mot_cmd[i], m_cmd[i]);
            check_bit($sformatf("amp_en[%0d]", i), amp_en[i], m_amp[i]);
        end

        // quadrature steps with ch2 preloaded near the sign boundary
        send(1'b1, make_addr(DEV_ENC, 2, OFS_ENC_POS), 32'h007F_FFF0);
        idle(4);
        for (int ch = 0; ch < NUM_ENCODERS; ch++) begin
            fwd = 16 + $urandom_range(8, 0);
            repeat (fwd) enc_step(ch, 1);
            repeat ((ch % 2 == 1) ? fwd + 5 : 3) enc_step(ch, -1);
        end
        idle(3);
        for (int ch = 0; ch < NUM_ENCODERS; ch++)
            send(1'b0, make_addr(DEV_ENC, ch, OFS_ENC_POS), '0);
        wait_drain();

        // illegal double transitions on ch1
        repeat (3) enc_step(1, 0);
        idle(2);
        send(1'b0, make_addr(DEV_ENC, 1, OFS_ENC_ERR), '0);
        send(1'b0, make_addr(DEV_ENC, 1, OFS_ENC_POS), '0);
        send(1'b1, make_addr(DEV_ENC, 1, OFS_ENC_ERR), '0);
        send(1'b0, make_addr(DEV_ENC, 1, OFS_ENC_ERR), '0);
        wait_drain();

        // watchdog trip, lockout and clear
        send(1'b1, make_addr(DEV_MOT, 0, OFS_MOT_AMP), 32'h1);
        send(1'b1, make_addr(DEV_MOT, 3, OFS_MOT_AMP), 32'h1);
        send(1'b1, make_addr(DEV_BOARD, 0, OFS_WDOG_PERIOD), 32'd20);
        send(1'b0, make_addr(DEV_BOARD, 0, OFS_WDOG_PERIOD), '0);
        wait_drain();
        cnt = 0;
        while (!wdog_timeout) begin
            idle(1);
            cnt = cnt + 1;
            if (cnt > 100) report_failure("watchdog timeout never asserted");
        end
        m_timeout = 1'b1;
        m_amp     = '0;
        idle(1);  // enables drop a cycle later
        for (int i = 0; i < NUM_MOTORS; i++)
            check_bit($sformatf("amp_en[%0d]", i), amp_en[i], 1'b0);
        send(1'b0, make_addr(DEV_BOARD, 0, OFS_STATUS), '0);
        send(1'b1, make_addr(DEV_MOT, 0, OFS_MOT_AMP), 32'h1);  // ignored
        send(1'b0, make_addr(DEV_MOT, 0, OFS_MOT_AMP), '0);
        send(1'b1, make_addr(DEV_BOARD, 0, OFS_STATUS), 32'h1);
        send(1'b0, make_addr(DEV_BOARD, 0, OFS_STATUS), '0);
        send(1'b1, make_addr(DEV_BOARD, 0, OFS_WDOG_PERIOD), '0);
        wait_drain();
        check_bit("wdog_timeout", wdog_timeout, m_timeout);

        // read burst against withheld response credits
        while (pend_cred != 0) idle(1);  // bridge back to its full credit count
        hold_cred = 1'b1;
        base      = rsp_count;
        for (int k = 0; k < 2 * REQ_DEPTH; k++)
            send(1'b0, make_addr(DEV_MOT, k % NUM_MOTORS, OFS_MOT_CMD), '0);
        idle(20);
        if (rsp_count - base > REQ_DEPTH)
            report_failure("more responses than response credits while credits were held");
        hold_cred = 1'b0;
        wait_drain();
        idle(4);
        if (credit_pulses != issued) begin
            report_failure($sformatf("%0d request credits returned for %0d requests",
                                     credit_pulses, issued));
        end else if (rsp_count != reads_issued) begin
            report_failure($sformatf("%0d responses received for %0d reads",
                                     rsp_count, reads_issued));
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

/* hdl/motor_ctrl_top.sv */
// motor controller register core top level
// bridge, encoder bank, motor bank and read mux
`timescale 1ns/1ps

module motor_ctrl_top import mc_pkg::*; #(
    parameter int NUM_MOTORS   = 4,
    parameter int NUM_ENCODERS = 4,
    parameter int REQ_DEPTH    = 4
) (
    input  logic                                 sysclk,
    input  logic                                 rst_n,
    input  logic                                 req_valid,
    input  logic                                 req_write,
    input  addr_t                                req_addr,
    input  data_t                                req_wdata,
    output logic                                 req_credit,
    input  logic                                 rsp_credit,
    output logic                                 rsp_valid,
    output data_t                                rsp_data,
    input  logic [BOARD_ID_W-1:0]                board_id,     // rotary switch
    input  logic [NUM_ENCODERS-1:0]              enc_a,
    input  logic [NUM_ENCODERS-1:0]              enc_b,
    output logic [NUM_MOTORS-1:0][MOT_CMD_W-1:0] mot_cmd,
    output logic [NUM_MOTORS-1:0]                amp_en,
    output logic                                 wdog_timeout
);

    // shared register bus
    addr_t reg_raddr;
    addr_t reg_waddr;
    data_t reg_wdata;
    data_t reg_rdata;
    logic  reg_wen;

    logic [NUM_ENCODERS-1:0][ENC_POS_W-1:0] enc_pos;
    logic [NUM_ENCODERS-1:0][ENC_ERR_W-1:0] enc_err;
    data_t                                  wdog_period;

    host_bridge #(.REQ_DEPTH(REQ_DEPTH)) host_bridge_inst (
        .sysclk, .rst_n,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_credit,
        .rsp_credit, .rsp_valid, .rsp_data,
        .reg_raddr, .reg_waddr, .reg_wdata, .reg_wen, .reg_rdata
    );

    encoder_bank #(.NUM_ENCODERS(NUM_ENCODERS)) encoder_bank_inst (
        .sysclk, .rst_n, .enc_a, .enc_b,
        .reg_waddr, .reg_wdata, .reg_wen,
        .enc_pos, .enc_err
    );

    motor_bank #(.NUM_MOTORS(NUM_MOTORS)) motor_bank_inst (
        .sysclk, .rst_n,
        .reg_waddr, .reg_wdata, .reg_wen,
        .mot_cmd, .amp_en, .wdog_period, .wdog_timeout
    );

    reg_read_mux #(.NUM_MOTORS(NUM_MOTORS), .NUM_ENCODERS(NUM_ENCODERS)) reg_read_mux_inst (
        .sysclk, .rst_n, .reg_raddr, .board_id,
        .enc_pos, .enc_err, .mot_cmd, .amp_en,
        .wdog_period, .wdog_timeout, .reg_rdata
    );

endmodule

/* hdl/reg_read_mux.sv */
// registered read data select over board status,
// encoder bank and motor bank
`timescale 1ns/1ps

module reg_read_mux import mc_pkg::*; #(
    parameter int NUM_MOTORS   = 4,
    parameter int NUM_ENCODERS = 4
) (
    input  logic                                   sysclk,
    input  logic                                   rst_n,
    input  addr_t                                  reg_raddr,
    input  logic [BOARD_ID_W-1:0]                  board_id,
    input  logic [NUM_ENCODERS-1:0][ENC_POS_W-1:0] enc_pos,
    input  logic [NUM_ENCODERS-1:0][ENC_ERR_W-1:0] enc_err,
    input  logic [NUM_MOTORS-1:0][MOT_CMD_W-1:0]   mot_cmd,
    input  logic [NUM_MOTORS-1:0]                  amp_en,
    input  data_t                                  wdog_period,
    input  logic                                   wdog_timeout,
    output data_t                                  reg_rdata
);

    data_t status;  // id 3..0, timeout 4, enables from 8
    data_t rd_sel;
    chan_t chan;
    ofs_t  ofs;

    assign chan = addr_chan(reg_raddr);
    assign ofs  = addr_ofs(reg_raddr);

    always_comb begin
        status                   = '0;
        status[BOARD_ID_W-1:0]   = board_id;
        status[4]                = wdog_timeout;
        status[8 +: NUM_MOTORS]  = amp_en;
    end

    // anything not matched below reads zero
    always_comb begin
        rd_sel = '0;
        case (addr_dev(reg_raddr))
            DEV_BOARD: begin
                if (ofs == OFS_STATUS)           rd_sel = status;
                else if (ofs == OFS_WDOG_PERIOD) rd_sel = wdog_period;
            end
            DEV_ENC: begin
                for (int i = 0; i < NUM_ENCODERS; i++)
                    if (chan == chan_t'(i)) begin
                        if (ofs == OFS_ENC_POS)  // sign-extend position
                            rd_sel = {{(32 - ENC_POS_W){enc_pos[i][ENC_POS_W-1]}}, enc_pos[i]};
                        else if (ofs == OFS_ENC_ERR)
                            rd_sel = data_t'(enc_err[i]);
                    end
            end
            DEV_MOT: begin
                for (int i = 0; i < NUM_MOTORS; i++)
                    if (chan == chan_t'(i)) begin
                        if (ofs == OFS_MOT_CMD)      rd_sel = data_t'(mot_cmd[i]);
                        else if (ofs == OFS_MOT_AMP) rd_sel = data_t'(amp_en[i]);
                    end
            end
            default: ;
        endcase
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) reg_rdata <= '0;
        else        reg_rdata <= rd_sel;  // one cycle after raddr
    end

endmodule

/* hdl/motor_bank.sv */
// motor command and amplifier enable registers
// board watchdog: period, timer and timeout flag
`timescale 1ns/1ps

module motor_bank import mc_pkg::*; #(
    parameter int NUM_MOTORS = 4
) (
    input  logic                                 sysclk,
    input  logic                                 rst_n,
    input  addr_t                                reg_waddr,
    input  data_t                                reg_wdata,
    input  logic                                 reg_wen,
    output logic [NUM_MOTORS-1:0][MOT_CMD_W-1:0] mot_cmd,
    output logic [NUM_MOTORS-1:0]                amp_en,
    output data_t                                wdog_period,
    output logic                                 wdog_timeout
);

    logic  wr_mot;
    logic  wr_board;
    chan_t wr_chan;
    ofs_t  wr_ofs;
    data_t wdog_cnt;  // cycles since last bus write

    assign wr_mot   = reg_wen && (addr_dev(reg_waddr) == DEV_MOT);
    assign wr_board = reg_wen && (addr_dev(reg_waddr) == DEV_BOARD);
    assign wr_chan  = addr_chan(reg_waddr);
    assign wr_ofs   = addr_ofs(reg_waddr);

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            mot_cmd <= '0;  // zero current out of reset
        end else begin
            for (int i = 0; i < NUM_MOTORS; i++)
                if (wr_mot && (wr_chan == chan_t'(i)) && (wr_ofs == OFS_MOT_CMD))
                    mot_cmd[i] <= reg_wdata[MOT_CMD_W-1:0];
        end
    end

    // enables are forced off and locked while the timeout is set
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            amp_en <= '0;
        end else if (wdog_timeout) begin
            amp_en <= '0;
        end else begin
            for (int i = 0; i < NUM_MOTORS; i++)
                if (wr_mot && (wr_chan == chan_t'(i)) && (wr_ofs == OFS_MOT_AMP))
                    amp_en[i] <= reg_wdata[0];
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            wdog_period  <= '0;
            wdog_cnt     <= '0;
            wdog_timeout <= 1'b0;
        end else begin
            if (wr_board && (wr_ofs == OFS_WDOG_PERIOD))
                wdog_period <= reg_wdata;     // zero disables the watchdog
            if (reg_wen)
                wdog_cnt <= '0;               // any host write kicks it
            else if ((wdog_period != '0) && !wdog_timeout) begin
                if (wdog_cnt >= wdog_period)
                    wdog_timeout <= 1'b1;
                else
                    wdog_cnt <= wdog_cnt + 1'b1;
            end
            if (wr_board && (wr_ofs == OFS_STATUS) && reg_wdata[0])
                wdog_timeout <= 1'b0;         // status bit 0 clears the timeout
        end
    end

    a_amp_off: assert property (@(posedge sysclk) disable iff (!rst_n)
        $rose(wdog_timeout) |=> (amp_en == '0))
        else $error("amplifiers still enabled after watchdog timeout");

endmodule

/* hdl/encoder_bank.sv */
// quadrature decoder bank: input sync, position counters
// with preload, saturating error counters
`timescale 1ns/1ps

module encoder_bank import mc_pkg::*; #(
    parameter int NUM_ENCODERS = 4
) (
    input  logic                                   sysclk,
    input  logic                                   rst_n,
    input  logic [NUM_ENCODERS-1:0]                enc_a,
    input  logic [NUM_ENCODERS-1:0]                enc_b,
    input  addr_t                                  reg_waddr,
    input  data_t                                  reg_wdata,
    input  logic                                   reg_wen,
    output logic [NUM_ENCODERS-1:0][ENC_POS_W-1:0] enc_pos,
    output logic [NUM_ENCODERS-1:0][ENC_ERR_W-1:0] enc_err
);

    logic  wr_enc;
    chan_t wr_chan;
    ofs_t  wr_ofs;

    assign wr_enc  = reg_wen && (addr_dev(reg_waddr) == DEV_ENC);
    assign wr_chan = addr_chan(reg_waddr);
    assign wr_ofs  = addr_ofs(reg_waddr);

    for (genvar i = 0; i < NUM_ENCODERS; i++) begin : g_chan
        logic [1:0]           sync1;   // {a, b}, first stage
        logic [1:0]           sync2;   // synchronized pair
        logic [1:0]           prev;    // pair seen last cycle
        logic [ENC_POS_W-1:0] pos;
        logic [ENC_ERR_W-1:0] err;
        logic                 step;
        logic                 both;
        logic                 up;
        logic                 sel;

        assign step = ^(sync2 ^ prev);   // exactly one bit moved
        assign both = &(sync2 ^ prev);   // illegal jump
        assign up   = sync2[1] ^ prev[0]; // a leads b when counting up
        assign sel  = wr_enc && (wr_chan == chan_t'(i));

        always_ff @(posedge sysclk) begin
            if (!rst_n) begin
                sync1 <= '0;
                sync2 <= '0;
                prev  <= '0;
                pos   <= '0;
                err   <= '0;
            end else begin
                sync1 <= {enc_a[i], enc_b[i]};
                sync2 <= sync1;
                prev  <= sync2;
                if (sel && (wr_ofs == OFS_ENC_POS))
                    pos <= reg_wdata[ENC_POS_W-1:0];  // preload wins over a step
                else if (step)
                    pos <= up ? pos + 1'b1 : pos - 1'b1;
                if (sel && (wr_ofs == OFS_ENC_ERR))
                    err <= '0;
                else if (both && (err != '1))
                    err <= err + 1'b1;               // sticks at max
            end
        end

        assign enc_pos[i] = pos;
        assign enc_err[i] = err;
    end

endmodule

/* hdl/host_bridge.sv */
// host bridge: request FIFO, credit counters
// register bus driver and read response generator
`timescale 1ns/1ps

module host_bridge import mc_pkg::*; #(
    parameter int REQ_DEPTH = 4
) (
    input  logic  sysclk,
    input  logic  rst_n,
    input  logic  req_valid,
    input  logic  req_write,
    input  addr_t req_addr,
    input  data_t req_wdata,
    output logic  req_credit,
    input  logic  rsp_credit,
    output logic  rsp_valid,
    output data_t rsp_data,
    output addr_t reg_raddr,
    output addr_t reg_waddr,
    output data_t reg_wdata,
    output logic  reg_wen,
    input  data_t reg_rdata
);

    localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(REQ_DEPTH + 1);

    logic             fifo_write [REQ_DEPTH];
    addr_t            fifo_addr  [REQ_DEPTH];
    data_t            fifo_wdata [REQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] fifo_cnt;   // entries held
    logic [CNT_W-1:0] rsp_cred;   // response credits left
    logic             head_write;
    logic             pop;
    logic             pop_rd;
    logic [1:0]       rd_tag;     // read in flight, stage 0 = raddr on bus

    function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
        return (p == PTR_W'(REQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head_write = fifo_write[rd_ptr];
    // writes never wait, reads need a response credit
    assign pop    = (fifo_cnt != '0) && (head_write || (rsp_cred != '0));
    assign pop_rd = pop && !head_write;

    always_ff @(posedge sysclk) begin
        if (req_valid) begin
            fifo_write[wr_ptr] <= req_write;
            fifo_addr[wr_ptr]  <= req_addr;
            fifo_wdata[wr_ptr] <= req_wdata;
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_cnt   <= '0;
            rsp_cred   <= CNT_W'(REQ_DEPTH);
            req_credit <= 1'b0;
            reg_wen    <= 1'b0;
            rd_tag     <= '0;
        end else begin
            if (req_valid) wr_ptr <= ptr_inc(wr_ptr);
            if (pop)       rd_ptr <= ptr_inc(rd_ptr);
            case ({req_valid, pop})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: ;
            endcase
            case ({rsp_credit, pop_rd})
                2'b10:   rsp_cred <= rsp_cred + 1'b1;  // host freed a slot
                2'b01:   rsp_cred <= rsp_cred - 1'b1;  // reserved by the read
                default: ;
            endcase
            req_credit <= pop;        // one credit back per pop
            reg_wen    <= pop && head_write;
            rd_tag     <= {rd_tag[0], pop_rd};
        end
    end

    // bus payload, held until the next pop of the same kind
    always_ff @(posedge sysclk) begin
        if (pop && head_write) begin
            reg_waddr <= fifo_addr[rd_ptr];
            reg_wdata <= fifo_wdata[rd_ptr];
        end
        if (pop_rd) reg_raddr <= fifo_addr[rd_ptr];
    end

    assign rsp_valid = rd_tag[1];  // mux output is registered, one stage late
    assign rsp_data  = reg_rdata;

    a_no_push_full: assert property (@(posedge sysclk) disable iff (!rst_n)
        req_valid |-> (fifo_cnt < CNT_W'(REQ_DEPTH)))
        else $error("request pushed into a full FIFO");
    a_cred_max: assert property (@(posedge sysclk) disable iff (!rst_n)
        rsp_cred <= CNT_W'(REQ_DEPTH))
        else $error("response credits above REQ_DEPTH");
    a_rsp_reserved: assert property (@(posedge sysclk) disable iff (!rst_n)
        rsp_valid |-> (rsp_cred < CNT_W'(REQ_DEPTH)))
        else $error("response sent without a reserved credit");

endmodule

/* hdl/mc_pkg.sv */
// register address map, device codes and offsets
// shared widths and address field helpers
package mc_pkg;

    typedef logic [15:0] addr_t;   // dev 15..12, chan 7..4, ofs 3..0
    typedef logic [31:0] data_t;
    typedef logic [3:0]  dev_t;
    typedef logic [3:0]  chan_t;
    typedef logic [3:0]  ofs_t;

    // device codes
    localparam dev_t DEV_BOARD = 4'h0;
    localparam dev_t DEV_ENC   = 4'h1;
    localparam dev_t DEV_MOT   = 4'h2;

    // board registers
    localparam ofs_t OFS_STATUS      = 4'd0;
    localparam ofs_t OFS_WDOG_PERIOD = 4'd1;
    // encoder registers
    localparam ofs_t OFS_ENC_POS = 4'd0;
    localparam ofs_t OFS_ENC_ERR = 4'd1;
    // motor registers
    localparam ofs_t OFS_MOT_CMD = 4'd0;
    localparam ofs_t OFS_MOT_AMP = 4'd1;

    localparam int ENC_POS_W  = 24;  // sign-extended on read
    localparam int ENC_ERR_W  = 16;  // saturating error count
    localparam int MOT_CMD_W  = 16;
    localparam int BOARD_ID_W = 4;

    function automatic dev_t addr_dev(addr_t a);
        return a[15:12];
    endfunction

    function automatic chan_t addr_chan(addr_t a);
        return a[7:4];
    endfunction

    function automatic ofs_t addr_ofs(addr_t a);
        return a[3:0];
    endfunction

endpackage
